// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    parameter int XLEN   = 32;
    parameter int VPPN_W = 19;  // va[31:13]
    parameter int PPN_W  = 20;

    // fetch exception codes
    typedef enum logic [5:0] {
        ECODE_PIF  = 6'h03,
        ECODE_PPI  = 6'h07,
        ECODE_ADEF = 6'h08,
        ECODE_TLBR = 6'h3f
    } ecode_t;

    typedef struct packed {
        logic       plv_met;  // window enabled for current plv
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic       pg;
        logic [1:0] plv;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_fetch_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              huge;  // 4 MB page
        logic [PPN_W-1:0]  ppn;
        logic [1:0]        plv;
        logic              v;
        logic              e;
    } tlb_entry_t;

    typedef struct packed {
        logic             found;
        logic             huge;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic             v;
    } tlb_result_t;

    typedef struct packed {
        logic            br_taken;  // one-cycle pulse
        logic            br_stall;
        logic [XLEN-1:0] br_target;
    } redirect_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic            excep;
        ecode_t          ecode;
        logic [XLEN-1:0] badv;
    } fetch_packet_t;

endpackage

`default_nettype wire

// File: hw/itlb.sv
`timescale 1ns/10ps
`default_nettype none

module itlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             we,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   windex,
    input  fetch_pkg::tlb_entry_t            wentry,
    input  logic [fetch_pkg::VPPN_W-1:0]     vppn,
    output fetch_pkg::tlb_result_t           res
);

    fetch_pkg::tlb_entry_t    entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]   hit;

    // only the present bits are cleared on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (we) begin
            entries[windex] <= wentry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entries[i].huge) begin
                hit[i] = entries[i].e && (entries[i].vppn[18:9] == vppn[18:9]);  // 4 MB
            end else begin
                hit[i] = entries[i].e && (entries[i].vppn == vppn);
            end
        end
    end

    // walk downwards so the lowest matching index is the one left in res
    always_comb begin
        res = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                res.found = 1'b1;
                res.huge  = entries[i].huge;
                res.ppn   = entries[i].ppn;
                res.plv   = entries[i].plv;
                res.v     = entries[i].v;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/addr_translate.sv
`timescale 1ns/10ps
`default_nettype none

module addr_translate (
    input  logic [fetch_pkg::XLEN-1:0]   va,
    input  fetch_pkg::csr_fetch_t        csr,
    output logic [fetch_pkg::VPPN_W-1:0] tlb_vppn,
    input  fetch_pkg::tlb_result_t       tlb_res,
    output logic [fetch_pkg::XLEN-1:0]   pa,
    output logic                         excep,
    output fetch_pkg::ecode_t            ecode
);

    logic                       hit_dmw0;
    logic                       hit_dmw1;
    logic                       use_tlb;
    logic [fetch_pkg::XLEN-1:0] tlb_pa;
    logic                       ex_adef;
    logic                       ex_tlbr;
    logic                       ex_pif;
    logic                       ex_ppi;

    assign tlb_vppn = va[31:13];

    assign hit_dmw0 = csr.dmw0.plv_met && (csr.dmw0.vseg == va[31:29]);
    assign hit_dmw1 = csr.dmw1.plv_met && (csr.dmw1.vseg == va[31:29]);
    assign use_tlb  = csr.pg && !hit_dmw0 && !hit_dmw1;

    // even and odd 4 KB halves share one ppn here
    assign tlb_pa = tlb_res.huge ? {tlb_res.ppn[19:10], va[21:0]}
                                 : {tlb_res.ppn, va[11:0]};

    always_comb begin
        if (!csr.pg) begin
            pa = va;                        // direct translation
        end else if (hit_dmw0) begin
            pa = {csr.dmw0.pseg, va[28:0]};
        end else if (hit_dmw1) begin
            pa = {csr.dmw1.pseg, va[28:0]};
        end else begin
            pa = tlb_pa;
        end
    end

    assign ex_adef = va[1] | va[0];
    assign ex_tlbr = use_tlb && !tlb_res.found;
    assign ex_pif  = use_tlb && tlb_res.found && !tlb_res.v;
    assign ex_ppi  = use_tlb && tlb_res.found && tlb_res.v && (csr.plv > tlb_res.plv);

    assign excep = ex_adef | ex_tlbr | ex_pif | ex_ppi;

    always_comb begin
        if (ex_adef) begin
            ecode = fetch_pkg::ECODE_ADEF;
        end else if (ex_tlbr) begin
            ecode = fetch_pkg::ECODE_TLBR;
        end else if (ex_pif) begin
            ecode = fetch_pkg::ECODE_PIF;
        end else begin
            ecode = fetch_pkg::ECODE_PPI;  // also the idle value
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          id_allowin,
    input  fetch_pkg::redirect_t          redirect,
    input  logic                          flush,
    input  logic [fetch_pkg::XLEN-1:0]    flush_entry,
    output logic [fetch_pkg::XLEN-1:0]    pre_pc,
    input  logic [fetch_pkg::XLEN-1:0]    pa,
    input  logic                          pre_excep,
    input  fetch_pkg::ecode_t             pre_ecode,
    output logic                          inst_req,
    output logic [fetch_pkg::XLEN-1:0]    inst_addr,
    input  logic                          addr_ok,
    input  logic                          data_ok,
    input  logic [fetch_pkg::XLEN-1:0]    rdata,
    output logic                          if_to_id_valid,
    output fetch_pkg::fetch_packet_t      if_to_id
);

    logic                       redir;
    logic                       accept;
    logic                       data_ok_v;     // return that is not being dropped
    logic                       pending;       // accepted read not yet returned
    logic                       cancel;
    logic [fetch_pkg::XLEN-1:0] next_pc;

    logic                       flush_q;
    logic [fetch_pkg::XLEN-1:0] flush_entry_q;
    logic                       br_q;
    logic [fetch_pkg::XLEN-1:0] br_target_q;

    logic                       pre_reqed;     // pre-fetch request accepted, still waiting
    logic [fetch_pkg::XLEN-1:0] pre_pc_q;
    logic                       pre_ir_valid;
    logic [fetch_pkg::XLEN-1:0] pre_ir;
    logic                       pre_excep_eff;
    logic                       pre_ready_go;
    logic                       pre_go;

    logic                       if_valid;
    logic [fetch_pkg::XLEN-1:0] if_pc;
    logic                       if_ir_valid;
    logic [fetch_pkg::XLEN-1:0] if_ir;
    logic                       if_excep;
    fetch_pkg::ecode_t          if_ecode;
    logic                       if_ready_go;
    logic                       if_allowin;

    assign redir     = flush | redirect.br_taken;
    assign accept    = inst_req & addr_ok;
    assign data_ok_v = data_ok & ~cancel;

    // captured flush first, then live flush, then branches
    assign next_pc = flush_q            ? flush_entry_q :
                     flush              ? flush_entry :
                     br_q               ? br_target_q :
                     redirect.br_taken  ? redirect.br_target :
                                          if_pc + 32'd4;

    assign pre_pc        = pre_reqed ? pre_pc_q : next_pc;
    assign pre_excep_eff = ~pre_reqed & pre_excep;
    assign pre_ready_go  = pre_reqed | accept | pre_excep_eff;
    assign pre_go        = pre_ready_go & if_allowin & ~redir;

    assign if_ready_go    = if_excep | if_ir_valid | (data_ok_v & ~pre_reqed);
    assign if_allowin     = ~if_valid | (if_ready_go & id_allowin);
    assign if_to_id_valid = if_valid & if_ready_go & ~redir;

    assign inst_req  = ~pre_reqed & (data_ok_v | if_ir_valid | if_allowin)
                       & ~redirect.br_stall & ~pre_excep;
    assign inst_addr = pa;

    // redirect that missed the request slot waits here
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_q <= 1'b0;
            br_q    <= 1'b0;
        end else if (accept | pre_go) begin
            flush_q <= 1'b0;
            br_q    <= 1'b0;
        end else begin
            if (flush) begin
                flush_q       <= 1'b1;
                flush_entry_q <= flush_entry;
            end
            if (redirect.br_taken) begin
                br_q        <= 1'b1;
                br_target_q <= redirect.br_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
            cancel  <= 1'b0;
        end else begin
            pending <= accept | (pending & ~data_ok);
            if (redir & pending & ~data_ok) begin
                cancel <= 1'b1;   // stale word still on its way
            end else if (data_ok) begin
                cancel <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else if (redir) begin
            pre_reqed    <= accept;   // request to the new target
            pre_ir_valid <= 1'b0;
        end else if (pre_go) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else begin
            if (accept) begin
                pre_reqed <= 1'b1;
            end
            if (data_ok_v & pre_reqed) begin
                pre_ir_valid <= 1'b1;
                pre_ir       <= rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pre_pc_q <= pre_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
            if_excep    <= 1'b0;
            if_pc       <= RESET_PC - 32'd4;
        end else if (redir) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (pre_go) begin
            if_valid    <= 1'b1;
            if_pc       <= pre_pc;
            if_excep    <= pre_excep_eff;
            if_ecode    <= pre_ecode;
            // a word already back in pre-fetch goes through the buffer
            if_ir_valid <= pre_reqed & (pre_ir_valid | data_ok_v);
            if_ir       <= pre_ir_valid ? pre_ir : rdata;
        end else if (if_to_id_valid & id_allowin) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (if_valid & data_ok_v & ~pre_reqed & ~if_ir_valid) begin
            if_ir_valid <= 1'b1;   // decode stalled
            if_ir       <= rdata;
        end
    end

    always_comb begin
        if_to_id.inst  = if_ir_valid ? if_ir : rdata;
        if_to_id.pc    = if_pc;
        if_to_id.excep = if_excep;
        if_to_id.ecode = if_ecode;
        if_to_id.badv  = if_pc;
    end

endmodule

`default_nettype wire

// File: hw/inst_ram.sv
`timescale 1ns/10ps
`default_nettype none

module inst_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       req,
    input  logic [fetch_pkg::XLEN-1:0] addr,
    output logic                       addr_ok,
    output logic                       data_ok,
    output logic [fetch_pkg::XLEN-1:0] rdata,
    input  logic                       we,
    input  logic [fetch_pkg::XLEN-1:0] waddr,
    input  logic [fetch_pkg::XLEN-1:0] wdata
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [fetch_pkg::XLEN-1:0] mem [RAM_WORDS];
    logic                       pending;
    logic                       accept;

    assign data_ok = pending;
    assign addr_ok = ~pending | data_ok;  // next read may overlap the return
    assign accept  = req & addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[addr[IDX_W+1:2]];  // word index wraps
        end
    end

    // preload side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[IDX_W+1:2]] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
    parameter logic [31:0] RESET_PC    = 32'h1c00_0000,
    parameter int          TLB_ENTRIES = 4,
    parameter int          RAM_WORDS   = 1024
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           ram_we,
    input  logic [fetch_pkg::XLEN-1:0]     ram_waddr,
    input  logic [fetch_pkg::XLEN-1:0]     ram_wdata,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
    input  fetch_pkg::tlb_entry_t          tlb_wentry,
    input  fetch_pkg::csr_fetch_t          csr,
    input  fetch_pkg::redirect_t           redirect,
    input  logic                           flush,
    input  logic [fetch_pkg::XLEN-1:0]     flush_entry,
    input  logic                           id_allowin,
    output logic                           if_to_id_valid,
    output fetch_pkg::fetch_packet_t       if_to_id
);

    logic [fetch_pkg::XLEN-1:0]   pre_pc;
    logic [fetch_pkg::XLEN-1:0]   pa;
    logic                         pre_excep;
    fetch_pkg::ecode_t            pre_ecode;
    logic [fetch_pkg::VPPN_W-1:0] tlb_vppn;
    fetch_pkg::tlb_result_t       tlb_res;
    logic                         inst_req;
    logic [fetch_pkg::XLEN-1:0]   inst_addr;
    logic                         addr_ok;
    logic                         data_ok;
    logic [fetch_pkg::XLEN-1:0]   rdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (
        .clk            (clk),
        .resetn         (resetn),
        .id_allowin     (id_allowin),
        .redirect       (redirect),
        .flush          (flush),
        .flush_entry    (flush_entry),
        .pre_pc         (pre_pc),
        .pa             (pa),
        .pre_excep      (pre_excep),
        .pre_ecode      (pre_ecode),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id)
    );

    addr_translate u_addr_translate (
        .va       (pre_pc),
        .csr      (csr),
        .tlb_vppn (tlb_vppn),
        .tlb_res  (tlb_res),
        .pa       (pa),
        .excep    (pre_excep),
        .ecode    (pre_ecode)
    );

    itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_itlb (
        .clk    (clk),
        .resetn (resetn),
        .we     (tlb_we),
        .windex (tlb_index),
        .wentry (tlb_wentry),
        .vppn   (tlb_vppn),
        .res    (tlb_res)
    );

    inst_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_inst_ram (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_req),
        .addr    (inst_addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .we      (ram_we),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 50  // 100 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch;

    localparam logic [31:0] RESET_PC  = 32'h1c00_0000;
    localparam int          RAM_WORDS = 4096;  // 16 KB so a 4 KB ppn reaches the word index
    localparam int          RAM_IDX_W = $clog2(RAM_WORDS);
    localparam int          TLB_N     = 4;

    logic                     clk;
    logic                     resetn;
    logic                     ram_we;
    logic [31:0]              ram_waddr;
    logic [31:0]              ram_wdata;
    logic                     tlb_we;
    logic [1:0]               tlb_index;
    fetch_pkg::tlb_entry_t    tlb_wentry;
    fetch_pkg::csr_fetch_t    csr;
    fetch_pkg::redirect_t     redirect;
    logic                     flush;
    logic [31:0]              flush_entry;
    logic                     id_allowin;
    logic                     if_to_id_valid;
    fetch_pkg::fetch_packet_t if_to_id;

    // reference model state
    logic [31:0]              mem_model [RAM_WORDS];
    fetch_pkg::tlb_entry_t    tlb_model [TLB_N];
    logic [31:0]              exp_pc;      // pc of the next packet decode should see
    int                       npackets;
    int                       seed;
    logic                     stall;
    logic                     backpressure;

    tb_clock u_clock (
        .clk (clk)
    );

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .TLB_ENTRIES (TLB_N),
        .RAM_WORDS   (RAM_WORDS)
    ) dut (
        .clk            (clk),
        .resetn         (resetn),
        .ram_we         (ram_we),
        .ram_waddr      (ram_waddr),
        .ram_wdata      (ram_wdata),
        .tlb_we         (tlb_we),
        .tlb_index      (tlb_index),
        .tlb_wentry     (tlb_wentry),
        .csr            (csr),
        .redirect       (redirect),
        .flush          (flush),
        .flush_entry    (flush_entry),
        .id_allowin     (id_allowin),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        abort_run($sformatf("FAIL %s expected %h actual %h", name, want, got));
    endtask

    function automatic fetch_pkg::csr_fetch_t csr_config(input logic pg, input logic [1:0] plv);
        fetch_pkg::csr_fetch_t c;
        c              = '0;
        c.pg           = pg;
        c.plv          = plv;
        c.dmw0.plv_met = 1'b1;
        c.dmw0.vseg    = 3'b100;  // 8000_0000 window
        c.dmw0.pseg    = 3'b000;
        return c;
    endfunction

    function automatic fetch_pkg::tlb_entry_t make_entry(input logic [18:0] vppn,
                                                        input logic huge,
                                                        input logic [19:0] ppn,
                                                        input logic [1:0] plv,
                                                        input logic v);
        fetch_pkg::tlb_entry_t t;
        t.vppn = vppn;
        t.huge = huge;
        t.ppn  = ppn;
        t.plv  = plv;
        t.v    = v;
        t.e    = 1'b1;
        return t;
    endfunction

    // what decode should receive for a fetch at pc
    function automatic fetch_pkg::fetch_packet_t expect_packet(input logic [31:0] pc);
        fetch_pkg::fetch_packet_t p;
        fetch_pkg::tlb_entry_t    hit;
        logic [31:0]              pa;
        logic                     found;
        logic                     match;
        p       = '0;
        hit     = '0;
        p.pc    = pc;
        p.badv  = pc;
        pa      = pc;
        found   = 1'b0;
        if (pc[1:0] != 2'b00) begin
            p.excep = 1'b1;
            p.ecode = fetch_pkg::ECODE_ADEF;
        end else if (csr.pg) begin
            if (csr.dmw0.plv_met && csr.dmw0.vseg == pc[31:29]) begin
                pa = {csr.dmw0.pseg, pc[28:0]};
            end else if (csr.dmw1.plv_met && csr.dmw1.vseg == pc[31:29]) begin
                pa = {csr.dmw1.pseg, pc[28:0]};
            end else begin
                for (int i = 0; i < TLB_N; i++) begin
                    if (tlb_model[i].huge) begin
                        match = tlb_model[i].e && (tlb_model[i].vppn[18:9] == pc[31:22]);
                    end else begin
                        match = tlb_model[i].e && (tlb_model[i].vppn == pc[31:13]);
                    end
                    if (match && !found) begin  // lowest index wins
                        found = 1'b1;
                        hit   = tlb_model[i];
                    end
                end
                if (!found) begin
                    p.excep = 1'b1;
                    p.ecode = fetch_pkg::ECODE_TLBR;
                end else if (!hit.v) begin
                    p.excep = 1'b1;
                    p.ecode = fetch_pkg::ECODE_PIF;
                end else if (csr.plv > hit.plv) begin
                    p.excep = 1'b1;
                    p.ecode = fetch_pkg::ECODE_PPI;
                end else if (hit.huge) begin
                    pa = {hit.ppn[19:10], pc[21:0]};
                end else begin
                    pa = {hit.ppn, pc[11:0]};
                end
            end
        end
        p.inst = mem_model[pa[RAM_IDX_W+1:2]];
        return p;
    endfunction

    task automatic check_packet(input fetch_pkg::fetch_packet_t got);
        fetch_pkg::fetch_packet_t want;
        want = expect_packet(exp_pc);
        assert (got.pc == want.pc)
            else report_mismatch("if_to_id.pc", want.pc, got.pc);
        assert (got.excep == want.excep)
            else report_mismatch("if_to_id.excep", 32'(want.excep), 32'(got.excep));
        if (want.excep) begin
            assert (got.ecode == want.ecode)
                else report_mismatch("if_to_id.ecode", 32'(want.ecode), 32'(got.ecode));
            assert (got.badv == want.badv)
                else report_mismatch("if_to_id.badv", want.badv, got.badv);
        end else begin
            assert (got.inst == want.inst)
                else report_mismatch("if_to_id.inst", want.inst, got.inst);
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    // one clock of stimulus, then the packet handshake is sampled before the next rising edge
    task automatic drive_cycle(input logic br, input logic [31:0] br_tgt,
                               input logic fl, input logic [31:0] fl_tgt,
                               input fetch_pkg::csr_fetch_t new_csr);
        @(negedge clk);
        redirect.br_taken  = br;
        redirect.br_target = br_tgt;
        redirect.br_stall  = stall;
        flush              = fl;
        flush_entry        = fl_tgt;
        csr                = new_csr;
        tlb_we             = 1'b0;
        if (backpressure) begin
            id_allowin = ($random(seed) & 32'h3) != 32'h0;
        end else begin
            id_allowin = 1'b1;
        end
        #1;
        if (if_to_id_valid && id_allowin) begin
            check_packet(if_to_id);
            npackets++;
        end
        if (fl) begin
            exp_pc = fl_tgt;  // flush beats a branch in the same cycle
        end else if (br) begin
            exp_pc = br_tgt;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 32'h0, 1'b0, 32'h0, csr);
    endtask

    task automatic wait_packets(input int n);
        int start;
        int cycles;
        start  = npackets;
        cycles = 0;
        while (npackets - start < n) begin
            if (cycles > 20 * n + 50) begin
                abort_run("timeout while waiting for fetch packets");
            end else begin
                drive_cycle(1'b0, 32'h0, 1'b0, 32'h0, csr);
                cycles++;
            end
        end
    endtask

    // decode held off for the write cycle
    task automatic fill_tlb(input int idx, input fetch_pkg::tlb_entry_t e);
        @(negedge clk);
        redirect.br_taken = 1'b0;
        flush             = 1'b0;
        id_allowin        = 1'b0;
        tlb_we            = 1'b1;
        tlb_index         = idx[1:0];
        tlb_wentry        = e;
        tlb_model[idx]    = e;
    endtask

    task automatic sequential_fetch();
        wait_packets(24);
    endtask

    task automatic backpressure_order();
        backpressure = 1'b1;
        wait_packets(48);
        backpressure = 1'b0;
    endtask

    task automatic redirect_and_flush();
        wait_packets(3);
        drive_cycle(1'b1, 32'h1c00_0400, 1'b0, 32'h0, csr);
        wait_packets(6);
        drive_cycle(1'b0, 32'h0, 1'b1, 32'h1c00_0800, csr);
        wait_packets(6);
        drive_cycle(1'b1, 32'h1c00_0a00, 1'b1, 32'h1c00_0c00, csr);
        wait_packets(6);
        backpressure = 1'b1;
        drive_cycle(1'b1, 32'h1c00_1000, 1'b0, 32'h0, csr);
        wait_packets(6);
        drive_cycle(1'b0, 32'h0, 1'b1, 32'h1c00_1400, csr);
        wait_packets(6);
        backpressure = 1'b0;
        // pulses that land while no request can go out
        stall = 1'b1;
        idle_cycles(2);
        drive_cycle(1'b1, 32'h1c00_1800, 1'b0, 32'h0, csr);
        idle_cycles(2);
        stall = 1'b0;
        wait_packets(6);
        stall = 1'b1;
        idle_cycles(2);
        drive_cycle(1'b0, 32'h0, 1'b1, 32'h1c00_1c00, csr);
        idle_cycles(2);
        stall = 1'b0;
        wait_packets(6);
    endtask

    task automatic paged_translation();
        // filled with paging off so the running stream is untouched
        fill_tlb(0, make_entry(19'h00201, 1'b0, 20'h00005, 2'd3, 1'b1));  // 4 KB
        fill_tlb(1, make_entry(19'h00400, 1'b1, 20'h00c00, 2'd3, 1'b1));  // 4 MB
        fill_tlb(2, make_entry(19'h00800, 1'b0, 20'h00011, 2'd3, 1'b0));
        fill_tlb(3, make_entry(19'h00a00, 1'b0, 20'h00022, 2'd0, 1'b1));
        wait_packets(4);
        drive_cycle(1'b1, 32'h8c00_0100, 1'b0, 32'h0, csr_config(1'b1, 2'd0));
        wait_packets(8);
        drive_cycle(1'b1, 32'h0040_2000, 1'b0, 32'h0, csr);
        wait_packets(8);
        // offset bits 21..12 nonzero, only a 4 MB match covers it
        drive_cycle(1'b1, 32'h0080_3040, 1'b0, 32'h0, csr);
        wait_packets(8);
    endtask

    task automatic fetch_exceptions();
        drive_cycle(1'b1, 32'h1c00_0102, 1'b0, 32'h0, csr_config(1'b0, 2'd0));
        wait_packets(3);
        drive_cycle(1'b1, 32'h0200_0000, 1'b0, 32'h0, csr_config(1'b1, 2'd0));
        wait_packets(3);
        drive_cycle(1'b1, 32'h0100_0000, 1'b0, 32'h0, csr);
        wait_packets(3);
        drive_cycle(1'b1, 32'h0140_0000, 1'b0, 32'h0, csr_config(1'b1, 2'd1));
        wait_packets(3);
        drive_cycle(1'b1, RESET_PC, 1'b0, 32'h0, csr_config(1'b0, 2'd0));
        wait_packets(4);
    endtask

    initial begin
        resetn             = 1'b0;
        ram_we             = 1'b0;
        ram_waddr          = 32'h0;
        ram_wdata          = 32'h0;
        tlb_we             = 1'b0;
        tlb_index          = 2'd0;
        tlb_wentry         = '0;
        csr                = csr_config(1'b0, 2'd0);
        redirect           = '0;
        redirect.br_stall  = 1'b1;  // no fetch until the RAM is loaded
        flush              = 1'b0;
        flush_entry        = 32'h0;
        id_allowin         = 1'b1;
        stall              = 1'b1;
        backpressure       = 1'b0;
        npackets           = 0;
        exp_pc             = RESET_PC;
        seed               = 32'h9186;
        for (int i = 0; i < TLB_N; i++) begin
            tlb_model[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!if_to_id_valid)
            else abort_run("if_to_id_valid was high during reset");
        resetn = 1'b1;

        for (int w = 0; w < RAM_WORDS; w++) begin
            @(negedge clk);
            ram_we       = 1'b1;
            ram_waddr    = w * 4;
            ram_wdata    = $random(seed);
            mem_model[w] = ram_wdata;
        end
        @(negedge clk);
        ram_we = 1'b0;
        stall  = 1'b0;

        sequential_fetch();
        backpressure_order();
        redirect_and_flush();
        paged_translation();
        fetch_exceptions();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/fetch_pkg.sv
hw/itlb.sv
hw/addr_translate.sv
hw/fetch_stage.sv
hw/inst_ram.sv
hw/fetch_top.sv
testbench/tb_clock.sv
testbench/tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fetch -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
